// ==== source/rst_defines.svh ====
// Build-time constants for the reset controller
// Included by any RTL or testbench file that needs a cycle count or a depth
// Override a value by defining the macro before this header is read

`ifndef RST_DEFINES_SVH
`define RST_DEFINES_SVH

// --------------------
// Reset stretch
// --------------------
// Cycles rst_n stays low after the last request cycle
`define RST_STRETCH_CYCLES 16

// --------------------
// Request sources
// --------------------
// Cycles without a kick before the watchdog bites
`define WDT_TIMEOUT_CYCLES 40
// Flops in the push-button synchronizer, at least 2
`define BTN_SYNC_STAGES 2

`endif

// ==== source/rst_pkg.sv ====
// Shared types for the reset controller
// Referenced by scoped name from the RTL and the testbench

package rst_pkg;

  // --------------------
  // Counter widths
  // --------------------

  // Stretch counter, bounds the longest stretch
  typedef logic [7:0] rst_ctr_t;

  // Watchdog down-counter
  typedef logic [15:0] wdt_ctr_t;

  // --------------------
  // Reset cause record
  // --------------------

  // Sticky flags, one per request source
  // por is the top bit, watchdog the bottom bit
  typedef struct packed {
    // Power-on reset seen
    logic por;
    // Push-button press seen
    logic button;
    // Software strobe seen
    logic software;
    // Watchdog bite seen
    logic watchdog;
  } rst_cause_t;

  // --------------------
  // Watchdog FSM
  // --------------------

  // IDLE while disabled, RUN while counting, BITE for one cycle
  typedef enum logic [1:0] {
    WDT_IDLE = 2'b00,
    WDT_RUN  = 2'b01,
    WDT_BITE = 2'b10
  } wdt_state_t;

endpackage

// ==== source/reset_sources.sv ====
// Reset request collection for the reset controller
// Synchronizes the push button, merges button, software and watchdog
// requests into one system request, and keeps the sticky cause record

`timescale 1ns/100ps
`include "rst_defines.svh"

module reset_sources (
  input  logic                clk,
  input  logic                rst_ctr_we,
  input  logic                button_n,
  input  logic                sw_reset_req,
  input  logic                wdt_bite,
  input  logic                cause_clear,
  output logic                sys_reset_req,
  output rst_pkg::rst_cause_t rst_cause
);

  // --------------------
  // Registers and wires
  // --------------------

  // Button synchronizer chain, stage 0 sees the pin
  logic [`BTN_SYNC_STAGES-1:0] btn_sync_reg;
  // Press level in the clk domain
  logic                        btn_press;

  rst_pkg::rst_cause_t cause_reg;
  rst_pkg::rst_cause_t cause_new;

  // --------------------
  // Button synchronizer
  // --------------------

  // Pin is active low, chain carries the inverted level
  // A press of N cycles comes out as N cycles of btn_press,
  // delayed by the chain depth
  always_ff @(posedge clk) begin
    if (rst_ctr_we) begin
      btn_sync_reg <= '0;
    end else begin
      btn_sync_reg <= {btn_sync_reg[`BTN_SYNC_STAGES-2:0], ~button_n};
    end
  end

  assign btn_press = btn_sync_reg[`BTN_SYNC_STAGES-1];

  // --------------------
  // Request merge
  // --------------------

  // Plain OR, no added latency
  // Every input is a flop output or a strobe from outside
  assign sys_reset_req = btn_press | sw_reset_req | wdt_bite;

  // --------------------
  // Sticky cause record
  // --------------------

  // Clear first, then set, so a request in the clear cycle survives
  always_comb begin
    if (cause_clear) begin
      cause_new = '0;
    end else begin
      cause_new = cause_reg;
    end

    if (btn_press) begin
      cause_new.button = 1'b1;
    end
    if (sw_reset_req) begin
      cause_new.software = 1'b1;
    end
    if (wdt_bite) begin
      cause_new.watchdog = 1'b1;
    end
  end

  // Power-on leaves only the por flag
  always_ff @(posedge clk) begin
    if (rst_ctr_we) begin
      cause_reg <= '{por: 1'b1, button: 1'b0, software: 1'b0, watchdog: 1'b0};
    end else begin
      cause_reg <= cause_new;
    end
  end

  assign rst_cause = cause_reg;

  // --------------------
  // Checks
  // --------------------

  // Software must always see some cause after power-on or a request
  a_cause_after_reset: assert property (
    @(posedge clk) (rst_ctr_we || sys_reset_req) |=> (rst_cause != '0)
  ) else $error("reset cause record empty after a reset");

endmodule

// ==== source/watchdog_timer.sv ====
// Watchdog timer for the reset controller
// Counts down while enabled, a kick or a low enable reloads it
// Bites with a one-cycle pulse on timeout, then reloads and keeps running

`timescale 1ns/100ps
`include "rst_defines.svh"

module watchdog_timer (
  input  logic clk,
  input  logic rst_ctr_we,
  input  logic wdt_enable,
  input  logic wdt_kick,
  output logic wdt_bite
);

  // Loaded on entry to RUN, bite follows WDT_TIMEOUT_CYCLES edges later
  localparam rst_pkg::wdt_ctr_t RELOAD = rst_pkg::wdt_ctr_t'(`WDT_TIMEOUT_CYCLES - 1);

  // --------------------
  // Registers and wires
  // --------------------
  rst_pkg::wdt_state_t state_reg;
  rst_pkg::wdt_state_t state_new;
  rst_pkg::wdt_ctr_t   ctr_reg;
  rst_pkg::wdt_ctr_t   ctr_new;

  // Only power-on resets the watchdog, rst_n does not reach it
  always_ff @(posedge clk) begin
    if (rst_ctr_we) begin
      state_reg <= rst_pkg::WDT_IDLE;
      ctr_reg   <= RELOAD;
    end else begin
      state_reg <= state_new;
      ctr_reg   <= ctr_new;
    end
  end

  // --------------------
  // Next-state logic
  // --------------------
  always_comb begin
    state_new = state_reg;
    ctr_new   = ctr_reg;

    case (state_reg)
      // Disabled, hold the full timeout
      rst_pkg::WDT_IDLE: begin
        ctr_new = RELOAD;
        if (wdt_enable) begin
          state_new = rst_pkg::WDT_RUN;
        end
      end

      rst_pkg::WDT_RUN: begin
        if (!wdt_enable) begin
          state_new = rst_pkg::WDT_IDLE;
          ctr_new   = RELOAD;
        end else if (wdt_kick) begin
          ctr_new = RELOAD;
        end else if (ctr_reg == '0) begin
          // Timeout reached
          state_new = rst_pkg::WDT_BITE;
          ctr_new   = RELOAD;
        end else begin
          ctr_new = ctr_reg - rst_pkg::wdt_ctr_t'(1);
        end
      end

      // Single cycle, then back to counting from the top
      rst_pkg::WDT_BITE: begin
        ctr_new = RELOAD;
        if (wdt_enable) begin
          state_new = rst_pkg::WDT_RUN;
        end else begin
          state_new = rst_pkg::WDT_IDLE;
        end
      end

      default: begin
        state_new = rst_pkg::WDT_IDLE;
        ctr_new   = RELOAD;
      end
    endcase
  end

  // Bite straight from the state flops
  assign wdt_bite = (state_reg == rst_pkg::WDT_BITE);

  // A kick buys a full timeout before the next bite
  a_kick_holds_off_bite: assert property (
    @(posedge clk) disable iff (rst_ctr_we) wdt_kick |=> !wdt_bite [*`WDT_TIMEOUT_CYCLES]
  ) else $error("watchdog bite within the timeout after a kick");

endmodule

// ==== source/reset_stretcher.sv ====
// Reset stretcher for the system reset
// Holds rst_n low while a request is present and for STRETCH_CYCLES
// cycles after it, and during and after power-on reset

`timescale 1ns/100ps
`include "rst_defines.svh"

module reset_stretcher #(
  parameter int unsigned STRETCH_CYCLES = `RST_STRETCH_CYCLES
) (
  input  logic clk,
  input  logic rst_ctr_we,
  input  logic sys_reset_req,
  output logic rst_n
);

  // Count at which rst_n is released
  localparam rst_pkg::rst_ctr_t STRETCH_END = rst_pkg::rst_ctr_t'(STRETCH_CYCLES);

  // Counter must be able to reach the end count
  if (STRETCH_CYCLES >= (1 << $bits(rst_pkg::rst_ctr_t))) begin : g_range_check
    $error("STRETCH_CYCLES exceeds the stretch counter range");
  end

  // --------------------
  // Registers and wires
  // --------------------
  logic              req_reg;
  rst_pkg::rst_ctr_t ctr_reg;
  rst_pkg::rst_ctr_t ctr_new;
  logic              ctr_we;
  logic              rst_n_reg;
  logic              rst_n_new;

  assign rst_n = rst_n_reg;

  // Request is registered once before it reaches the counter
  always_ff @(posedge clk) begin
    if (rst_ctr_we) begin
      req_reg <= 1'b0;
    end else begin
      req_reg <= sys_reset_req;
    end

    rst_n_reg <= rst_n_new;
    if (ctr_we) begin
      ctr_reg <= ctr_new;
    end
  end

  // --------------------
  // Stretch logic
  // --------------------
  // Power-on or a live request restarts the count with rst_n low
  // Otherwise count up with rst_n low, then hold at the end count
  always_comb begin
    rst_n_new = 1'b1;
    ctr_new   = '0;
    ctr_we    = 1'b0;

    if (rst_ctr_we || req_reg) begin
      rst_n_new = 1'b0;
      ctr_we    = 1'b1;
    end else if (ctr_reg < STRETCH_END) begin
      rst_n_new = 1'b0;
      ctr_new   = ctr_reg + rst_pkg::rst_ctr_t'(1);
      ctr_we    = 1'b1;
    end
  end

  // Once the registered request drops, rst_n stays low for the whole stretch
  a_hold_after_req: assert property (
    @(posedge clk) disable iff (rst_ctr_we) $fell(req_reg) |-> !rst_n [*STRETCH_CYCLES + 1]
  ) else $error("rst_n released before the stretch completed");

endmodule

// ==== source/reset_ctrl_top.sv ====
// Top level of the reset controller
// Connects the request sources, the watchdog and the reset stretcher
// clk and the power-on reset rst_ctr_we come from outside

`timescale 1ns/100ps

module reset_ctrl_top (
  input  logic                clk,
  input  logic                rst_ctr_we,
  // Push button, active low, asynchronous
  input  logic                button_n,
  input  logic                sw_reset_req,
  input  logic                wdt_enable,
  input  logic                wdt_kick,
  input  logic                cause_clear,
  output logic                rst_n,
  output rst_pkg::rst_cause_t rst_cause
);

  // --------------------
  // Internal wires
  // --------------------
  // One-cycle timeout pulse
  logic wdt_bite;
  // Merged request level
  logic sys_reset_req;

  // Button sync, request merge and cause record
  reset_sources u_reset_sources (
    .clk           (clk),
    .rst_ctr_we    (rst_ctr_we),
    .button_n      (button_n),
    .sw_reset_req  (sw_reset_req),
    .wdt_bite      (wdt_bite),
    .cause_clear   (cause_clear),
    .sys_reset_req (sys_reset_req),
    .rst_cause     (rst_cause)
  );

  // Runs from power-on reset only, so it survives its own bite
  watchdog_timer u_watchdog_timer (
    .clk        (clk),
    .rst_ctr_we (rst_ctr_we),
    .wdt_enable (wdt_enable),
    .wdt_kick   (wdt_kick),
    .wdt_bite   (wdt_bite)
  );

  // Stretch length from the shared default
  reset_stretcher u_reset_stretcher (
    .clk           (clk),
    .rst_ctr_we    (rst_ctr_we),
    .sys_reset_req (sys_reset_req),
    .rst_n         (rst_n)
  );

endmodule

// ==== tests/tb_reset_table.svh ====
// Stimulus and expected-value table for the reset controller testbench
// Included inside the testbench module, one row per test step
// Width 0 asks for a random width, latency 0 skips the latency check

// --------------------
// Row layout
// --------------------
typedef enum logic [2:0] {
  ACT_POR,
  ACT_CLEAR,
  ACT_SW,
  ACT_BUTTON,
  ACT_WDT_BITE,
  ACT_WDT_KICK
} action_t;

// Width is request cycles, or timeout periods for the kicked watchdog
typedef struct packed {
  action_t             action;
  logic [7:0]          width;
  rst_pkg::rst_cause_t exp_cause;
  logic [7:0]          exp_latency;
} row_t;

localparam int MAX_ROWS = 32;

// Negedges from driving a request to first seeing rst_n low
// Request seen at edge 0, registered at edge 1, rst_n low after edge 2
localparam int LAT_SW  = 2;
localparam int LAT_BTN = `BTN_SYNC_STAGES + 2;
// Bite lands a full timeout after enable, then one edge to be seen
localparam int LAT_WDT = `WDT_TIMEOUT_CYCLES + 3;

row_t table_rows [0:MAX_ROWS-1];
int   row_count = 0;

task automatic add_row(input action_t action, input int width, input logic [3:0] cause,
                       input int latency);
  row_t r;
  r.action      = action;
  r.width       = width[7:0];
  r.exp_cause   = cause;
  r.exp_latency = latency[7:0];
  table_rows[row_count] = r;
  row_count++;
endtask

// Cause bits are por, button, software, watchdog
task automatic load_table();
  add_row(ACT_POR,      0, 4'b1000, 0);
  add_row(ACT_SW,       1, 4'b1010, LAT_SW);
  add_row(ACT_CLEAR,    0, 4'b0000, 0);
  add_row(ACT_BUTTON,   0, 4'b0100, LAT_BTN);
  add_row(ACT_CLEAR,    0, 4'b0000, 0);
  add_row(ACT_WDT_BITE, 1, 4'b0001, LAT_WDT);
  // Kicked in time for four timeout periods
  add_row(ACT_WDT_KICK, 4, 4'b0001, 0);
  add_row(ACT_CLEAR,    0, 4'b0000, 0);
  // Two sources accumulate
  add_row(ACT_BUTTON,   3, 4'b0100, LAT_BTN);
  add_row(ACT_SW,       1, 4'b0110, LAT_SW);
  add_row(ACT_SW,       4, 4'b0110, LAT_SW);
  add_row(ACT_POR,      0, 4'b1000, 0);
  add_row(ACT_BUTTON,   0, 4'b1100, LAT_BTN);
  add_row(ACT_WDT_BITE, 1, 4'b1101, LAT_WDT);
  add_row(ACT_CLEAR,    0, 4'b0000, 0);
  add_row(ACT_SW,       0, 4'b0010, LAT_SW);
endtask

// ==== tests/tb_reset_ctrl.sv ====
// Testbench for the reset controller top level
// Walks the stimulus table, measures rst_n fall latency and low time,
// and checks the sticky reset-cause record after every step

`timescale 1ns/100ps
`include "rst_defines.svh"

module tb_reset_ctrl;

  localparam int CLK_HALF  = 2;
  localparam int STRETCH   = `RST_STRETCH_CYCLES;
  localparam int TIMEOUT   = `WDT_TIMEOUT_CYCLES;
  // Random request widths are 1 to 8 cycles
  localparam int MAX_WIDTH = 8;
  // Negedges a reset step may take before it counts as stuck
  localparam int ROW_LIMIT = 2 * TIMEOUT + STRETCH + 64;

  logic                clk;
  logic                rst_ctr_we;
  logic                button_n;
  logic                sw_reset_req;
  logic                wdt_enable;
  logic                wdt_kick;
  logic                cause_clear;
  logic                rst_n;
  rst_pkg::rst_cause_t rst_cause;

  logic [31:0] lfsr_state   = 32'h4d4f_0887;
  bit          table_loaded = 1'b0;

  `include "tb_reset_table.svh"

  reset_ctrl_top DUT (
    .clk          (clk),
    .rst_ctr_we   (rst_ctr_we),
    .button_n     (button_n),
    .sw_reset_req (sw_reset_req),
    .wdt_enable   (wdt_enable),
    .wdt_kick     (wdt_kick),
    .cause_clear  (cause_clear),
    .rst_n        (rst_n),
    .rst_cause    (rst_cause)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // --------------------
  // Random numbers
  // --------------------
  // Right-shift Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int count, output int unsigned value);
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = (value << 1) | lfsr_state[0];
    end
  endtask

  // --------------------
  // Checks
  // --------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_cause(input rst_pkg::rst_cause_t got, input rst_pkg::rst_cause_t exp);
    logic [3:0] got_bits;
    logic [3:0] exp_bits;
    got_bits = got;
    exp_bits = exp;
    if (got_bits !== exp_bits) begin
      fail_run($sformatf("mismatch rst_cause: got 0x%h expected 0x%h", got_bits, exp_bits));
    end
  endtask

  task automatic check_low_cycles(input rst_pkg::rst_ctr_t got, input rst_pkg::rst_ctr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch rst_n low cycles: got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic check_latency(input rst_pkg::rst_ctr_t got, input rst_pkg::rst_ctr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch rst_n fall latency: got 0x%h expected 0x%h", got, exp));
    end
  endtask

  // --------------------
  // Stimulus steps
  // --------------------
  // Button pin is active low, the other sources active high
  task automatic drive_source(input action_t action, input logic on);
    case (action)
      ACT_SW:       sw_reset_req = on;
      ACT_BUTTON:   button_n     = ~on;
      ACT_WDT_BITE: wdt_enable   = on;
      default:      ;
    endcase
  endtask

  // Four cycles of power-on, then count the stretch
  task automatic do_por(output int low);
    int k;
    low = 0;
    k   = 0;
    rst_ctr_we = 1'b1;
    repeat (4) @(negedge clk);
    if (rst_n !== 1'b0) begin
      fail_run("rst_n was not low during power-on reset");
    end
    rst_ctr_we = 1'b0;
    @(negedge clk);
    while (rst_n !== 1'b1) begin
      low++;
      k++;
      if (k > ROW_LIMIT) begin
        fail_run("rst_n stayed low after power-on reset ended");
      end
      @(negedge clk);
    end
  endtask

  // Drive one request, release it after its width, time the reset
  task automatic run_request(input action_t action, input int width, output int latency,
                             output int low);
    int k;
    bit seen_low;
    bit done;
    k        = 0;
    seen_low = 1'b0;
    done     = 1'b0;
    latency  = 0;
    low      = 0;
    if (rst_n !== 1'b1) begin
      fail_run("rst_n was low before a reset request");
    end
    drive_source(action, 1'b1);
    while (!done) begin
      @(negedge clk);
      k++;
      if (k == width && action != ACT_WDT_BITE) begin
        drive_source(action, 1'b0);
      end
      if (rst_n !== 1'b1) begin
        if (!seen_low) begin
          latency = k;
          // Disable before the next bite comes round
          if (action == ACT_WDT_BITE) begin
            drive_source(action, 1'b0);
          end
        end
        seen_low = 1'b1;
        low++;
      end else if (seen_low) begin
        done = 1'b1;
      end
      if (k > ROW_LIMIT) begin
        fail_run("rst_n did not complete a reset after a request");
      end
    end
  endtask

  // Kick gaps stay below the timeout, so rst_n must stay high
  task automatic run_kicked(input int periods);
    int          k;
    int          next_kick;
    int unsigned v;
    rand_bits(5, v);
    next_kick  = 1 + (v % (TIMEOUT - 2));
    wdt_enable = 1'b1;
    for (k = 1; k <= periods * TIMEOUT; k++) begin
      @(negedge clk);
      wdt_kick = 1'b0;
      if (rst_n !== 1'b1) begin
        fail_run("rst_n went low while the watchdog was kicked in time");
      end
      if (k == next_kick) begin
        wdt_kick = 1'b1;
        rand_bits(5, v);
        next_kick = k + 1 + (v % (TIMEOUT - 2));
      end
    end
    @(negedge clk);
    wdt_kick   = 1'b0;
    wdt_enable = 1'b0;
    // A late bite would show within two edges
    repeat (3) begin
      @(negedge clk);
      if (rst_n !== 1'b1) begin
        fail_run("rst_n went low after the kicked watchdog was disabled");
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    int          width;
    int          latency;
    int          low;
    int unsigned v;
    @(negedge clk);
    width = r.width;
    if (width == 0) begin
      rand_bits(3, v);
      width = v + 1;
    end
    case (r.action)
      ACT_POR: begin
        do_por(low);
        check_low_cycles(rst_pkg::rst_ctr_t'(low), rst_pkg::rst_ctr_t'(STRETCH));
      end
      // Flags must read zero one edge after the strobe
      ACT_CLEAR: begin
        cause_clear = 1'b1;
        @(negedge clk);
        cause_clear = 1'b0;
      end
      ACT_WDT_KICK: begin
        run_kicked(width);
      end
      default: begin
        run_request(r.action, width, latency, low);
        if (r.exp_latency != 0) begin
          check_latency(rst_pkg::rst_ctr_t'(latency), rst_pkg::rst_ctr_t'(r.exp_latency));
        end
        check_low_cycles(rst_pkg::rst_ctr_t'(low), rst_pkg::rst_ctr_t'(width + STRETCH));
      end
    endcase
    check_cause(rst_cause, r.exp_cause);
  endtask

  task automatic idle_gap();
    int unsigned v;
    rand_bits(3, v);
    repeat (v + 2) @(negedge clk);
  endtask

  // Worst-case cycles for one row, gap and row start included
  function automatic int row_budget(input row_t r);
    int cycles;
    case (r.action)
      ACT_POR:      cycles = 4 + STRETCH + 4;
      ACT_CLEAR:    cycles = 2;
      ACT_WDT_KICK: cycles = r.width * TIMEOUT + 6;
      ACT_WDT_BITE: cycles = TIMEOUT + 4 + STRETCH + 2;
      default:      cycles = MAX_WIDTH + `BTN_SYNC_STAGES + 4 + STRETCH;
    endcase
    return cycles + 10;
  endfunction

  // --------------------
  // Run watchdog
  // --------------------
  initial begin : timeout_watch
    int budget;
    int i;
    wait (table_loaded);
    budget = 0;
    for (i = 0; i < row_count; i++) begin
      budget += row_budget(table_rows[i]);
    end
    // Double the table sum as margin
    #((2 * budget + 100) * 2 * CLK_HALF);
    fail_run("simulation timed out");
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main_flow
    int i;
    rst_ctr_we   = 1'b1;
    button_n     = 1'b1;
    sw_reset_req = 1'b0;
    wdt_enable   = 1'b0;
    wdt_kick     = 1'b0;
    cause_clear  = 1'b0;
    load_table();
    table_loaded = 1'b1;
    for (i = 0; i < row_count; i++) begin
      apply_row(table_rows[i]);
      idle_gap();
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+source
+incdir+tests
source/rst_pkg.sv
source/reset_sources.sv
source/watchdog_timer.sv
source/reset_stretcher.sv
source/reset_ctrl_top.sv
tests/tb_reset_ctrl.sv
